// File: Makefile
TOP = tb_ifu_frontend

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: list.f
verilog/ifu_pkg.sv
verilog/ifu_fetch.sv
verilog/ifu_ipack.sv
verilog/ifu_ibuf.sv
verilog/ifu_frontend_top.sv
tb/tb_wb_imem.sv
tb/tb_ifu_frontend.sv

// File: tb/tb_ifu_frontend.sv
/*
  Testbench for the instruction-fetch front end. Runs a table of fetch
  runs through the DUT against a Wishbone memory model and checks every
  decode transfer against the expected PC sequence and memory contents.
*/

`timescale 1ns/1ps

module tb_ifu_frontend;

  import ifu_pkg::*;

  localparam int unsigned IBUF_DEPTH      = IBUF_DEPTH_DEF;
  localparam logic [31:0] RESET_PC        = RESET_PC_DEF;
  localparam int unsigned ERR_BIT         = 12;
  localparam int unsigned RST_CYCLES      = 16;
  localparam int unsigned NUM_ROWS        = 6;
  localparam int unsigned CYCLES_PER_WORD = 200;
  localparam logic [31:0] SEED            = 32'h28ec87d9;

  // One fetch run
  typedef struct packed {
    logic [31:0] start_pc;
    logic [31:0] n_words;
    logic [31:0] rdy_pct;
    // Cycles of dec_rdy low before the run drains
    logic [31:0] hold_cycles;
    // Zero means no redirect inside the run
    logic [31:0] redir_after;
    logic [31:0] redir_pc;
  } row_t;

  logic        forever_cpuclk;
  logic        rst;
  logic        redirect_vld;
  logic [31:0] redirect_pc;
  logic        wb_cyc;
  logic        wb_stb;
  logic [31:0] wb_adr;
  logic        wb_ack;
  logic        wb_err;
  logic [31:0] wb_dat_i;
  logic        dec_rdy;
  fetch_pkt_t  dec_pkt;
  logic        dec_vld;

  row_t        rows [NUM_ROWS];
  logic        table_loaded = 1'b0;
  // PC the next decode transfer must carry
  logic [31:0] exp_pc;

  // ------------------------------
  // Clock, DUT and memory
  // ------------------------------
  initial forever_cpuclk = 1'b0;
  always #10 forever_cpuclk = ~forever_cpuclk;

  ifu_frontend_top #(
    .IBUF_DEPTH (IBUF_DEPTH),
    .RESET_PC   (RESET_PC)
  ) DUT (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .redirect_vld   (redirect_vld),
    .redirect_pc    (redirect_pc),
    .wb_ack         (wb_ack),
    .wb_err         (wb_err),
    .wb_dat_i       (wb_dat_i),
    .dec_rdy        (dec_rdy),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_adr         (wb_adr),
    .dec_pkt        (dec_pkt),
    .dec_vld        (dec_vld)
  );

  tb_wb_imem #(
    .ERR_BIT (ERR_BIT)
  ) u_imem (
    .clk (forever_cpuclk),
    .rst (rst),
    .cyc (wb_cyc),
    .stb (wb_stb),
    .adr (wb_adr),
    .ack (wb_ack),
    .err (wb_err),
    .dat (wb_dat_i)
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic load_table();
    // start pc, words, ready %, hold, redirect after, redirect target
    rows[0] = '{RESET_PC,     32'd24, 32'd100, 32'd0,  32'd0,  32'h0};
    rows[1] = '{32'h0000_0400, 32'd40, 32'd30,  32'd0,  32'd0,  32'h0};
    rows[2] = '{32'h0000_0800, 32'd20, 32'd100, 32'd0,  32'd6,  32'h0000_2400};
    // Crosses into the error region at 0x1000
    rows[3] = '{32'h0000_0FF0, 32'd12, 32'd70,  32'd0,  32'd0,  32'h0};
    // Long hold fills FIFO and package entry
    rows[4] = '{32'h0000_0200, 32'd16, 32'd100, 32'd40, 32'd0,  32'h0};
    rows[5] = '{32'h0000_2800, 32'd30, 32'd50,  32'd0,  32'd10, 32'h0000_0100};
    table_loaded = 1'b1;
  endtask

  // Memory word for a PC as seen through the front end
  function automatic fetch_pkt_t expected_pkt(input logic [31:0] pc);
    fetch_pkt_t pkt;
    pkt.pc = pc;
    if (pc[ERR_BIT]) begin
      pkt.inst = 32'h0;
      pkt.expt = EXPT_ACC_ERR;
    end else begin
      pkt.inst = ~pc;
      pkt.expt = EXPT_NONE;
    end
    return pkt;
  endfunction

  function automatic logic draw_ready(input logic [31:0] pct);
    return ($urandom % 100) < pct;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0d ns: %s got %h expected %h", $time, name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic score_transfer();
    fetch_pkt_t exp_pkt;
    exp_pkt = expected_pkt(exp_pc);
    check_value("dec_pkt.pc", dec_pkt.pc, exp_pkt.pc);
    check_value("dec_pkt.inst", dec_pkt.inst, exp_pkt.inst);
    check_value("dec_pkt.expt", 32'(dec_pkt.expt), 32'(exp_pkt.expt));
    exp_pc = exp_pc + 32'd4;
  endtask

  // One redirect cycle in which nothing may transfer
  task automatic apply_redirect(input logic [31:0] target);
    redirect_vld <= 1'b1;
    redirect_pc  <= target;
    dec_rdy      <= 1'b1;
    @(posedge forever_cpuclk);
    check_value("dec_vld", 32'(dec_vld), 32'd0);
    redirect_vld <= 1'b0;
    exp_pc = target;
  endtask

  // ------------------------------
  // Stimulus and decode checker
  // ------------------------------
  initial begin
    int unsigned r;
    int unsigned got;
    void'($urandom(SEED));
    rst          <= 1'b1;
    redirect_vld <= 1'b0;
    redirect_pc  <= 32'h0;
    dec_rdy      <= 1'b0;
    load_table();
    repeat (RST_CYCLES) @(posedge forever_cpuclk);
    // Bus and decode port idle in reset
    check_value("wb_cyc", 32'(wb_cyc), 32'd0);
    check_value("wb_stb", 32'(wb_stb), 32'd0);
    check_value("dec_vld", 32'(dec_vld), 32'd0);
    rst <= 1'b0;
    @(posedge forever_cpuclk);
    check_value("wb_cyc", 32'(wb_cyc), 32'd0);
    // First bus cycle opens at RESET_PC one clock after reset falls
    @(posedge forever_cpuclk);
    check_value("wb_cyc", 32'(wb_cyc), 32'd1);
    check_value("wb_stb", 32'(wb_stb), 32'd1);
    check_value("wb_adr", wb_adr, RESET_PC);
    for (r = 0; r < NUM_ROWS; r++) begin
      // First run starts from reset and later ones by redirect
      if (r == 0) begin
        exp_pc = rows[r].start_pc;
      end else begin
        apply_redirect(rows[r].start_pc);
      end
      if (rows[r].hold_cycles != 0) begin
        dec_rdy <= 1'b0;
        repeat (rows[r].hold_cycles) @(posedge forever_cpuclk);
        check_value("dec_vld", 32'(dec_vld), 32'd1);
      end
      got = 0;
      while (got < rows[r].n_words) begin
        dec_rdy <= draw_ready(rows[r].rdy_pct);
        @(posedge forever_cpuclk);
        if (dec_vld && dec_rdy) begin
          score_transfer();
          got++;
          if (got == rows[r].redir_after) begin
            apply_redirect(rows[r].redir_pc);
          end
        end
      end
    end
    $display("RESULT: PASS");
    $finish;
  end

  // Budget scales with the words in the table
  initial begin
    int unsigned budget;
    wait (table_loaded);
    budget = RST_CYCLES;
    for (int i = 0; i < NUM_ROWS; i++) begin
      budget = budget + CYCLES_PER_WORD * rows[i].n_words;
    end
    repeat (budget) @(posedge forever_cpuclk);
    $display("timeout: decode port stopped delivering words");
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tb/tb_wb_imem.sv
/*
  Wishbone classic slave model of instruction memory for the testbench.
  Answers each request after 0 to 3 random wait cycles. Read data is the
  inverted address; addresses with bit ERR_BIT set answer with err.
*/

`timescale 1ns/1ps

module tb_wb_imem #(
  parameter int unsigned ERR_BIT = 12
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        cyc,
  input  logic        stb,
  input  logic [31:0] adr,
  output logic        ack,
  output logic        err,
  output logic [31:0] dat
);

  // Request seen and counting wait cycles
  logic       busy;
  // One-cycle response pulse
  logic       resp = 1'b0;
  logic [1:0] wait_cnt;

  always @(posedge clk) begin : resp_seq
    logic [1:0] draw;
    if (rst) begin
      busy     <= 1'b0;
      resp     <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (resp) begin
      // Next request can start on the next clock
      resp <= 1'b0;
    end else if (busy) begin
      if (wait_cnt == 2'd0) begin
        busy <= 1'b0;
        resp <= 1'b1;
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end else if (cyc && stb) begin
      draw = 2'($urandom % 4);
      if (draw == 2'd0) begin
        resp <= 1'b1;
      end else begin
        busy     <= 1'b1;
        wait_cnt <= draw - 2'd1;
      end
    end
  end

  // Address is held stable by the master until the response
  assign ack = resp && !adr[ERR_BIT];
  assign err = resp && adr[ERR_BIT];
  assign dat = resp ? ~adr : 32'h0;

endmodule

// File: verilog/ifu_fetch.sv
/*
  Fetch unit of the front end. Holds the fetch PC and runs one
  Wishbone classic read at a time to instruction memory. Each bus
  response becomes a fetch packet in the same cycle; a reissue from
  the package stage repeats the address instead of advancing.
*/

`timescale 1ns/1ps

module ifu_fetch #(
  parameter logic [31:0] RESET_PC = ifu_pkg::RESET_PC_DEF
) (
  input  logic                forever_cpuclk,
  input  logic                rst,
  input  logic                redirect_vld,
  input  logic [31:0]         redirect_pc,
  input  logic                ipack_reissue,
  input  logic                wb_ack,
  input  logic                wb_err,
  input  logic [31:0]         wb_dat_i,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic [31:0]         wb_adr,
  output ifu_pkg::fetch_pkt_t fetch_pkt,
  output logic                fetch_pkt_vld
);

  import ifu_pkg::*;

  fetch_state_e state;
  // Current fetch address, doubles as the bus address
  logic [31:0]  pc;
  // Redirect target parked while a stale cycle drains
  logic [31:0]  redir_pc;
  logic         bus_done;

  // ------------------------------
  // Bus side
  // ------------------------------

  // Either response ends the cycle
  assign bus_done = wb_ack || wb_err;

  // Cycle open in BUS and in DROP alike
  assign wb_cyc = (state == FETCH_BUS) || (state == FETCH_DROP);
  assign wb_stb = wb_cyc;
  assign wb_adr = pc;

  // ------------------------------
  // Packet to the package stage
  // ------------------------------

  // Responses in DROP are stale and never become packets
  assign fetch_pkt_vld = (state == FETCH_BUS) && bus_done;

  assign fetch_pkt.pc   = pc;
  // Error wins over ack, no data on an error
  assign fetch_pkt.inst = wb_err ? 32'h0 : wb_dat_i;
  assign fetch_pkt.expt = wb_err ? EXPT_ACC_ERR : EXPT_NONE;

  // ------------------------------
  // FSM and PC
  // ------------------------------
  always_ff @(posedge forever_cpuclk) begin
    if (rst) begin
      state <= FETCH_IDLE;
      pc    <= RESET_PC;
    end else begin
      case (state)
        FETCH_IDLE: begin
          // First cycle starts on the next clock
          state <= FETCH_BUS;
          if (redirect_vld) begin
            pc <= redirect_pc;
          end
        end
        FETCH_BUS: begin
          if (redirect_vld && !bus_done) begin
            // Keep adr stable, drain the open cycle first
            state <= FETCH_DROP;
          end else if (redirect_vld) begin
            pc <= redirect_pc;
          end else if (bus_done && !ipack_reissue) begin
            pc <= pc + 32'd4;
          end
        end
        FETCH_DROP: begin
          if (bus_done) begin
            state <= FETCH_BUS;
            // A newer redirect in the same cycle takes over
            pc    <= redirect_vld ? redirect_pc : redir_pc;
          end
        end
        default: begin
          state <= FETCH_IDLE;
        end
      endcase
    end
  end

  // Target capture, only read in DROP
  always_ff @(posedge forever_cpuclk) begin
    if (redirect_vld) begin
      redir_pc <= redirect_pc;
    end
  end

  // Wishbone classic: request held until the slave answers
  a_adr_stable: assert property (@(posedge forever_cpuclk) disable iff (rst)
    wb_stb && !bus_done |=> wb_stb && $stable(wb_adr));

endmodule

// File: verilog/ifu_frontend_top.sv
/*
  Top level of the instruction-fetch front end.
  Wishbone classic master toward instruction memory, valid/ready
  packet port toward decode, redirect input that flushes all stages.
*/

`timescale 1ns/1ps

module ifu_frontend_top #(
  parameter int unsigned IBUF_DEPTH = ifu_pkg::IBUF_DEPTH_DEF,
  parameter logic [31:0] RESET_PC   = ifu_pkg::RESET_PC_DEF
) (
  input  logic                forever_cpuclk,
  input  logic                rst,
  input  logic                redirect_vld,
  input  logic [31:0]         redirect_pc,
  input  logic                wb_ack,
  input  logic                wb_err,
  input  logic [31:0]         wb_dat_i,
  input  logic                dec_rdy,
  output logic                wb_cyc,
  output logic                wb_stb,
  output logic [31:0]         wb_adr,
  output ifu_pkg::fetch_pkt_t dec_pkt,
  output logic                dec_vld
);

  import ifu_pkg::*;

  // Fetch to package stage
  fetch_pkt_t fetch_pkt;
  logic       fetch_pkt_vld;
  logic       ipack_reissue;

  // Package stage to buffer
  fetch_pkt_t ipack_pkt;
  logic       ipack_vld;
  logic       ibuf_stall;

  // ------------------------------
  // Producer
  // ------------------------------
  ifu_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .redirect_vld   (redirect_vld),
    .redirect_pc    (redirect_pc),
    .ipack_reissue  (ipack_reissue),
    .wb_ack         (wb_ack),
    .wb_err         (wb_err),
    .wb_dat_i       (wb_dat_i),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_adr         (wb_adr),
    .fetch_pkt      (fetch_pkt),
    .fetch_pkt_vld  (fetch_pkt_vld)
  );

  // ------------------------------
  // Package stage
  // ------------------------------
  ifu_ipack u_ipack (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .redirect_vld   (redirect_vld),
    .fetch_pkt      (fetch_pkt),
    .fetch_pkt_vld  (fetch_pkt_vld),
    .ibuf_stall     (ibuf_stall),
    .ipack_reissue  (ipack_reissue),
    .ipack_pkt      (ipack_pkt),
    .ipack_vld      (ipack_vld)
  );

  // ------------------------------
  // Consumer
  // ------------------------------
  ifu_ibuf #(
    .IBUF_DEPTH (IBUF_DEPTH)
  ) u_ibuf (
    .forever_cpuclk (forever_cpuclk),
    .rst            (rst),
    .redirect_vld   (redirect_vld),
    .ipack_pkt      (ipack_pkt),
    .ipack_vld      (ipack_vld),
    .dec_rdy        (dec_rdy),
    .ibuf_stall     (ibuf_stall),
    .dec_pkt        (dec_pkt),
    .dec_vld        (dec_vld)
  );

endmodule

// File: verilog/ifu_ibuf.sv
/*
  Instruction buffer FIFO in front of decode. Accepts packets from
  the package stage, delivers them on a valid/ready port, and stalls
  the package stage while full. Redirect clears it at the next edge.
*/

`timescale 1ns/1ps

module ifu_ibuf #(
  parameter int unsigned IBUF_DEPTH = ifu_pkg::IBUF_DEPTH_DEF
) (
  input  logic                forever_cpuclk,
  input  logic                rst,
  input  logic                redirect_vld,
  input  ifu_pkg::fetch_pkt_t ipack_pkt,
  input  logic                ipack_vld,
  input  logic                dec_rdy,
  output logic                ibuf_stall,
  output ifu_pkg::fetch_pkt_t dec_pkt,
  output logic                dec_vld
);

  import ifu_pkg::*;

  localparam int unsigned PTR_W = $clog2(IBUF_DEPTH);
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(IBUF_DEPTH);

  fetch_pkt_t       mem [IBUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // One extra bit so full and empty differ
  logic [PTR_W:0]   cnt;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  // ------------------------------
  // Status and handshakes
  // ------------------------------
  assign full  = (cnt == FULL_CNT);
  assign empty = (cnt == '0);

  // Full means stall even if decode pops this cycle
  assign ibuf_stall = full;
  assign push       = ipack_vld && !full;

  // Nothing leaves in the redirect cycle
  assign dec_vld = !empty && !redirect_vld;
  assign pop     = dec_vld && dec_rdy;
  assign dec_pkt = mem[rd_ptr];

  // ------------------------------
  // Pointers and count
  // ------------------------------
  always_ff @(posedge forever_cpuclk) begin
    if (rst || redirect_vld) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // Storage
  always_ff @(posedge forever_cpuclk) begin
    if (push) begin
      mem[wr_ptr] <= ipack_pkt;
    end
  end

  // No push when full and no pop when empty keep the count within the depth
  a_cnt_in_range: assert property (@(posedge forever_cpuclk) disable iff (rst)
    cnt <= FULL_CNT);

  // Pointer distance and count track each other
  a_ptr_cnt_match: assert property (@(posedge forever_cpuclk) disable iff (rst)
    (wr_ptr - rd_ptr) == cnt[PTR_W-1:0]);

endmodule

// File: verilog/ifu_ipack.sv
/*
  One-entry instruction package stage between fetch and the
  instruction buffer. Takes a fetch packet, holds it while the buffer
  stalls, and asks fetch to reissue a packet it cannot take.
  Redirect empties the entry at the next edge.
*/

`timescale 1ns/1ps

module ifu_ipack (
  input  logic                forever_cpuclk,
  input  logic                rst,
  input  logic                redirect_vld,
  input  ifu_pkg::fetch_pkt_t fetch_pkt,
  input  logic                fetch_pkt_vld,
  input  logic                ibuf_stall,
  output logic                ipack_reissue,
  output ifu_pkg::fetch_pkt_t ipack_pkt,
  output logic                ipack_vld
);

  import ifu_pkg::*;

  fetch_pkt_t entry_pkt;
  logic       entry_vld;
  logic       pkt_in_vld;
  logic       entry_create;
  logic       entry_retire;

  // ------------------------------
  // Create and retire
  // ------------------------------

  // Packets arriving during a redirect are dropped
  assign pkt_in_vld = fetch_pkt_vld && !redirect_vld;

  // Refuse only when full and the buffer will not drain us
  assign entry_create = pkt_in_vld && !(entry_vld && ibuf_stall);

  // Buffer takes the entry whenever it is not stalling
  assign entry_retire = !ibuf_stall;

  // Valid bit, flush wins over create
  always_ff @(posedge forever_cpuclk) begin
    if (rst || redirect_vld) begin
      entry_vld <= 1'b0;
    end else if (entry_create) begin
      entry_vld <= 1'b1;
    end else if (entry_retire) begin
      entry_vld <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge forever_cpuclk) begin
    if (entry_create) begin
      entry_pkt <= fetch_pkt;
    end
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  assign ipack_vld      = entry_vld;
  assign ipack_pkt.pc   = entry_pkt.pc;
  // Empty entry shows no instruction and no exception
  assign ipack_pkt.inst = entry_vld ? entry_pkt.inst : 32'h0;
  assign ipack_pkt.expt = entry_vld ? entry_pkt.expt : EXPT_NONE;

  // Refused packet, fetch repeats the same address
  assign ipack_reissue = pkt_in_vld && entry_vld && ibuf_stall;

  // A stalled full entry keeps its word until the buffer drains
  a_hold_on_stall: assert property (@(posedge forever_cpuclk) disable iff (rst)
    entry_vld && ibuf_stall && !redirect_vld |=> entry_vld && $stable(entry_pkt));

endmodule

// File: verilog/ifu_pkg.sv
/*
  Shared types and defaults for the instruction-fetch front end.
  Holds the fetch packet, the exception code, the fetch FSM states
  and the default top-level parameter values. Import where needed.
*/

package ifu_pkg;

  // ------------------------------
  // Default parameter values
  // ------------------------------

  // Instruction buffer depth, power of two and at least 2
  localparam int unsigned IBUF_DEPTH_DEF = 4;

  // Start PC after reset
  localparam logic [31:0] RESET_PC_DEF = 32'h0000_0000;

  // ------------------------------
  // Enumerations
  // ------------------------------

  // Exception code carried with each instruction
  typedef enum logic [1:0] {
    EXPT_NONE    = 2'd0,
    EXPT_ACC_ERR = 2'd1
  } fetch_expt_e;

  // Fetch master FSM
  // FETCH_DROP waits out a bus cycle made stale by a redirect
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_BUS  = 2'd1,
    FETCH_DROP = 2'd2
  } fetch_state_e;

  // ------------------------------
  // Fetch packet, 66 bits
  // ------------------------------
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    fetch_expt_e expt;
  } fetch_pkt_t;

endpackage
